// ==== compile.f ====
common/window_pkg.sv
common/framer_ctrl_pkg.sv
common/fill_if.sv
source/sample_fifo.sv
window_buffer/window_fill_fsm.sv
window_buffer/fill_counter.sv
window_buffer/window_ring.sv
source/framer_apb_regs.sv
source/window_framer_top.sv
test/tb_window_framer.sv

// ==== test/tb_window_framer.sv ====
module tb_window_framer import window_pkg::*, framer_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WATCHDOG_CYCLES = 4 * WINDOW_LEN * 8 + 1000;
    localparam logic [APB_DATA_W-1:0] FULL_MASK = APB_DATA_W'(1) << STATUS_FULL_BIT;
    localparam logic [APB_DATA_W-1:0] FIFO_MASK = APB_DATA_W'(1) << STATUS_FIFO_FULL_BIT;

    logic                  clk;
    logic                  rst_n;
    logic                  sample_valid_i;
    sample_t               sample_data_i;
    logic                  sample_ready_o;
    logic                  rd_en_i;
    sample_t               rd_data_o;
    logic                  rd_valid_o;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    logic [APB_ADDR_W-1:0] paddr_i;
    logic [APB_DATA_W-1:0] pwdata_i;
    logic [APB_DATA_W-1:0] prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;

    sample_t sent_q [$];  // every sample the DUT accepted, in stream order
    sample_t next_data;
    int      cur_frame;
    int      mon_idx;     // window index of the next read

    window_framer_top i_window_framer_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_valid_i (sample_valid_i),
        .sample_data_i  (sample_data_i),
        .sample_ready_o (sample_ready_o),
        .rd_en_i        (rd_en_i),
        .rd_data_o      (rd_data_o),
        .rd_valid_o     (rd_valid_o),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o)
    );

    always #5 clk = ~clk;

    task automatic stop_on_failure(string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_sample(string name, sample_t got, sample_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("[ERROR] %0d ns: %s got %h expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_reg(string name, logic [APB_DATA_W-1:0] got,
                             logic [APB_DATA_W-1:0] exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("[ERROR] %0d ns: %s got %h expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("[ERROR] %0d ns: %s got %b expected %b",
                                      $time, name, got, exp));
        end
    endtask

    // element k of frame f is stream sample f*HOP_LEN + k
    function automatic sample_t expected_sample(int frame, int idx);
        return sent_q[frame * HOP_LEN + idx];
    endfunction

    task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] wdata,
                              output logic [APB_DATA_W-1:0] rdata, output logic err);
        @(negedge clk);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk);
        penable_i = 1'b1;
        #1;
        rdata = prdata_o;
        err   = pslverr_o;
        check_flag("pready_o", pready_o, 1'b1);
        @(negedge clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic read_reg(logic [APB_ADDR_W-1:0] addr, logic [APB_DATA_W-1:0] exp,
                            string name);
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_flag("pslverr_o", err, 1'b0);
        check_reg(name, rdata, exp);
    endtask

    task automatic write_advance(bit taken);
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        apb_access(1'b1, CTRL_ADDR, APB_DATA_W'(1) << CTRL_ADVANCE_BIT, rdata, err);
        check_flag("pslverr_o", err, 1'b0);
        if (taken) begin
            cur_frame = cur_frame + 1;
            mon_idx   = 0;
        end
    endtask

    task automatic send_samples(int n);
        int gap;
        bit taken;
        for (int i = 0; i < n; i++) begin
            gap = $urandom_range(3, 1);
            repeat (gap) begin
                @(negedge clk);
                sample_valid_i = 1'b0;
            end
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                sample_valid_i = 1'b1;
                sample_data_i  = next_data;
                taken          = sample_ready_o;  // transfer on the coming edge
            end
            sent_q.push_back(next_data);
            next_data = sample_t'($urandom);
        end
        @(negedge clk);
        sample_valid_i = 1'b0;
    endtask

    // hold a sample on the port while the FIFO is full
    task automatic offer_blocked(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            sample_valid_i = 1'b1;
            sample_data_i  = next_data;
            check_flag("sample_ready_o", sample_ready_o, 1'b0);
        end
        @(negedge clk);
        sample_valid_i = 1'b0;
    endtask

    task automatic read_elements(int n);
        int done;
        done = 0;
        while (done < n) begin
            @(negedge clk);
            if ($urandom_range(3, 0) == 0) begin
                rd_en_i = 1'b0;
            end else begin
                rd_en_i = 1'b1;
                if (rd_valid_o) begin
                    done++;
                end
            end
        end
        @(negedge clk);
        rd_en_i = 1'b0;
    endtask

    task automatic wait_full();
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        rdata = '0;
        while (!rdata[STATUS_FULL_BIT]) begin
            apb_access(1'b0, STATUS_ADDR, '0, rdata, err);
        end
    endtask

    always @(negedge clk) begin
        int pos;
        #1;  // inputs settled, next rising edge consumes
        if (rst_n && rd_en_i && rd_valid_o) begin
            pos = cur_frame * HOP_LEN + mon_idx;
            if (mon_idx >= WINDOW_LEN) begin
                stop_on_failure("read accepted past the end of the window");
            end else if (pos >= sent_q.size()) begin
                stop_on_failure("read accepted before its sample was sent");
            end
            check_sample("rd_data_o", rd_data_o, expected_sample(cur_frame, mon_idx));
            mon_idx++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_failure("watchdog expired, the run hung before all checks finished");
    end

    initial begin
        logic [APB_DATA_W-1:0] rdata;
        logic                  err;
        int                    avail;
        int                    missing;
        clk            = 1'b0;
        rst_n          = 1'b0;
        sample_valid_i = 1'b0;
        sample_data_i  = '0;
        rd_en_i        = 1'b0;
        psel_i         = 1'b0;
        penable_i      = 1'b0;
        pwrite_i       = 1'b0;
        paddr_i        = '0;
        pwdata_i       = '0;
        cur_frame      = 0;
        mon_idx        = 0;
        void'($urandom(32'h3705832c));
        next_data = sample_t'($urandom);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        apb_access(1'b0, 4'hC, '0, rdata, err);  // unmapped
        check_flag("pslverr_o", err, 1'b1);
        apb_access(1'b1, 4'hC, 32'h1, rdata, err);
        check_flag("pslverr_o", err, 1'b1);
        read_reg(CTRL_ADDR, '0, "prdata_o CTRL");

        // first window, advance during the fill must be dropped
        send_samples(40);
        write_advance(1'b0);
        read_reg(STATUS_ADDR, '0, "prdata_o STATUS");
        read_reg(FRAMES_ADDR, 32'd1, "prdata_o FRAMES");
        repeat (20) @(negedge clk);
        read_elements(sent_q.size());
        check_flag("rd_valid_o", rd_valid_o, 1'b0);
        missing = WINDOW_LEN - sent_q.size();
        fork
            send_samples(missing);
            read_elements(missing);
        join
        wait_full();
        read_reg(STATUS_ADDR, FULL_MASK, "prdata_o STATUS");
        read_reg(FRAMES_ADDR, 32'd1, "prdata_o FRAMES");
        check_flag("rd_valid_o", rd_valid_o, 1'b0);

        for (int f = 1; f <= 3; f++) begin
            send_samples(FIFO_DEPTH);  // nothing pops while idle
            check_flag("sample_ready_o", sample_ready_o, 1'b0);
            read_reg(STATUS_ADDR, FULL_MASK | FIFO_MASK, "prdata_o STATUS");
            offer_blocked(6);
            write_advance(1'b1);
            read_elements(WINDOW_LEN - HOP_LEN);  // kept part, no new samples
            repeat (30) @(negedge clk);
            avail = sent_q.size() - f * HOP_LEN;
            read_elements(avail - (WINDOW_LEN - HOP_LEN));
            check_flag("rd_valid_o", rd_valid_o, 1'b0);
            write_advance(1'b0);  // refill still running
            read_reg(STATUS_ADDR, '0, "prdata_o STATUS");
            missing = WINDOW_LEN - avail;
            fork
                send_samples(missing);
                read_elements(missing);
            join
            wait_full();
            read_reg(FRAMES_ADDR, 32'(f + 1), "prdata_o FRAMES");
            check_flag("rd_valid_o", rd_valid_o, 1'b0);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== source/window_framer_top.sv ====
module window_framer_top import window_pkg::*, framer_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sample_valid_i,
    input  sample_t               sample_data_i,
    output logic                  sample_ready_o,
    input  logic                  rd_en_i,
    output sample_t               rd_data_o,
    output logic                  rd_valid_o,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);

    sample_t fifo_data;
    logic    fifo_pop;
    logic    fifo_empty;
    logic    fifo_full;
    logic    frame_start;
    logic    idle;
    logic    advance;

    fill_if i_fill_if ();

    assign sample_ready_o = !fifo_full;  // back-pressure

    sample_fifo i_sample_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (sample_valid_i),
        .push_data_i (sample_data_i),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_data),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full)
    );

    window_fill_fsm i_window_fill_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .advance_i     (advance),
        .fifo_empty_i  (fifo_empty),
        .fifo_pop_o    (fifo_pop),
        .frame_start_o (frame_start),
        .idle_o        (idle),
        .fill          (i_fill_if.ctrl)
    );

    fill_counter i_fill_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .fill  (i_fill_if.count)
    );

    window_ring i_window_ring (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_data_i  (fifo_data),
        .rd_en_i    (rd_en_i),
        .rd_data_o  (rd_data_o),
        .rd_valid_o (rd_valid_o),
        .fill       (i_fill_if.store)
    );

    framer_apb_regs i_framer_apb_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .idle_i        (idle),
        .fifo_full_i   (fifo_full),
        .frame_start_i (frame_start),
        .advance_o     (advance)
    );

endmodule

// ==== source/framer_apb_regs.sv ====
module framer_apb_regs import framer_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic                  idle_i,
    input  logic                  fifo_full_i,
    input  logic                  frame_start_i,
    output logic                  advance_o
);

    logic                  access;
    logic                  addr_ok;
    logic                  advance_q;
    logic [APB_DATA_W-1:0] frames_q;
    logic [APB_DATA_W-1:0] status_word;

    assign access   = psel_i && penable_i;  // no wait states
    assign pready_o = 1'b1;

    always_comb begin
        unique case (paddr_i)
            CTRL_ADDR, STATUS_ADDR, FRAMES_ADDR: addr_ok = 1'b1;
            default:                             addr_ok = 1'b0;
        endcase
    end

    assign pslverr_o = access && !addr_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            advance_q <= 1'b0;
            frames_q  <= '0;
        end else begin
            // dropped silently unless the window is complete
            advance_q <= access && pwrite_i && (paddr_i == CTRL_ADDR)
                         && pwdata_i[CTRL_ADVANCE_BIT] && idle_i;
            if (frame_start_i) begin
                frames_q <= frames_q + 1'b1;
            end
        end
    end

    assign advance_o = advance_q;

    always_comb begin
        status_word                       = '0;
        status_word[STATUS_FULL_BIT]      = idle_i;
        status_word[STATUS_FIFO_FULL_BIT] = fifo_full_i;
    end

    always_comb begin
        unique case (paddr_i)
            STATUS_ADDR: prdata_o = status_word;
            FRAMES_ADDR: prdata_o = frames_q;
            default:     prdata_o = '0;  // CTRL is write-only
        endcase
    end

endmodule

// ==== window_buffer/window_ring.sv ====
module window_ring import window_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t wr_data_i,
    input  logic    rd_en_i,
    output sample_t rd_data_o,
    output logic    rd_valid_o,
    fill_if.store   fill
);

    sample_t   store_q [WINDOW_LEN];
    win_idx_t  wr_ptr_q;
    win_idx_t  base_q;    // oldest sample of the current window
    win_idx_t  rd_idx_q;  // position inside the window
    win_idx_t  rd_addr;
    fill_cnt_t filled;
    logic      loading;

    // a + b modulo WINDOW_LEN, both operands already below WINDOW_LEN
    function automatic win_idx_t wrap_add(win_idx_t a, win_idx_t b);
        logic [WIN_IDX_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= (WIN_IDX_W + 1)'(WINDOW_LEN)) begin
            sum = sum - (WIN_IDX_W + 1)'(WINDOW_LEN);
        end
        return win_idx_t'(sum);
    endfunction

    assign loading = fill.load_full || fill.load_hop;

    always_ff @(posedge clk) begin
        if (fill.write_strobe) begin
            store_q[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            base_q   <= '0;
            rd_idx_q <= '0;
        end else begin
            if (fill.write_strobe) begin
                wr_ptr_q <= wrap_add(wr_ptr_q, win_idx_t'(1));
            end
            if (fill.load_hop) begin
                base_q <= wrap_add(base_q, win_idx_t'(HOP_LEN));
            end
            if (loading) begin
                rd_idx_q <= '0;
            end else if (rd_en_i && rd_valid_o) begin
                rd_idx_q <= rd_idx_q + 1'b1;  // parks at WINDOW_LEN
            end
        end
    end

    // number of window entries already holding data
    assign filled = fill.zero ? fill_cnt_t'(WINDOW_LEN)
                              : fill_cnt_t'(WINDOW_LEN) - fill.remaining;

    assign rd_valid_o = !loading && (rd_idx_q < filled);
    assign rd_addr    = wrap_add(base_q, rd_idx_q);
    assign rd_data_o  = store_q[rd_addr];

endmodule

// ==== window_buffer/fill_counter.sv ====
module fill_counter import window_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    fill_if.count fill
);

    fill_cnt_t remaining_q;

    // starts at a full window missing, so nothing reads as valid before LOAD
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining_q <= fill_cnt_t'(WINDOW_LEN);
        end else if (fill.load_full) begin
            remaining_q <= fill_cnt_t'(WINDOW_LEN);
        end else if (fill.load_hop) begin
            remaining_q <= fill_cnt_t'(HOP_LEN);
        end else if (fill.write_strobe && remaining_q != '0) begin
            remaining_q <= remaining_q - 1'b1;
        end
    end

    assign fill.remaining = remaining_q;
    assign fill.zero      = (remaining_q == '0);

endmodule

// ==== window_buffer/window_fill_fsm.sv ====
module window_fill_fsm import framer_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic advance_i,
    input  logic fifo_empty_i,
    output logic fifo_pop_o,
    output logic frame_start_o,
    output logic idle_o,
    fill_if.ctrl fill
);

    fill_state_t state_q;
    fill_state_t state_d;
    logic        hop_q;  // set once the first window is done

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= INIT;
            hop_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && advance_i) begin
                hop_q <= 1'b1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            INIT:    state_d = LOAD;
            LOAD:    state_d = REQUEST;
            REQUEST: begin
                // counter is checked here, after the last write has landed
                if (fill.zero) begin
                    state_d = IDLE;
                end else if (!fifo_empty_i) begin
                    state_d = WRITE;
                end
            end
            WRITE:   state_d = REQUEST;
            IDLE: begin
                if (advance_i) begin
                    state_d = LOAD;
                end
            end
            default: state_d = INIT;
        endcase
    end

    assign fill.load_full    = (state_q == LOAD) && !hop_q;
    assign fill.load_hop     = (state_q == LOAD) && hop_q;
    assign fill.write_strobe = (state_q == WRITE);

    // head sample leaves the fifo on the same edge it is stored
    assign fifo_pop_o    = (state_q == WRITE);
    assign frame_start_o = (state_q == LOAD);
    assign idle_o        = (state_q == IDLE);

endmodule

// ==== source/sample_fifo.sv ====
module sample_fifo import window_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    push_i,
    input  sample_t push_data_i,
    input  logic    pop_i,
    output sample_t pop_data_o,
    output logic    empty_o,
    output logic    full_o
);

    sample_t               mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_PTR_W:0]   count_q;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign pop_data_o = mem_q[rd_ptr_q];  // head entry
    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));

endmodule

// ==== common/fill_if.sv ====
interface fill_if import window_pkg::*; ();

    logic      load_full;     // start of the initial fill
    logic      load_hop;      // start of a hop refill
    logic      write_strobe;  // one sample written to the ring
    fill_cnt_t remaining;
    logic      zero;

    modport ctrl (
        output load_full,
        output load_hop,
        output write_strobe,
        input  zero
    );

    modport count (
        input  load_full,
        input  load_hop,
        input  write_strobe,
        output remaining,
        output zero
    );

    modport store (
        input load_full,
        input load_hop,
        input write_strobe,
        input remaining,
        input zero
    );

endinterface

// ==== common/framer_ctrl_pkg.sv ====
package framer_ctrl_pkg;

    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    typedef enum logic [2:0] {
        INIT,
        LOAD,
        REQUEST,
        WRITE,
        IDLE
    } fill_state_t;

    typedef enum logic [APB_ADDR_W-1:0] {
        CTRL_ADDR   = 4'h0,
        STATUS_ADDR = 4'h4,
        FRAMES_ADDR = 4'h8
    } apb_addr_e;

    localparam int CTRL_ADVANCE_BIT     = 0;
    localparam int STATUS_FULL_BIT      = 0;  // window completely filled
    localparam int STATUS_FIFO_FULL_BIT = 1;

endpackage

// ==== common/window_pkg.sv ====
package window_pkg;

    localparam int SAMPLE_W   = 16;
    localparam int WINDOW_LEN = 306;
    localparam int HOP_LEN    = 123;
    localparam int FIFO_DEPTH = 8;

    // index must also hold WINDOW_LEN itself (read index parks there)
    localparam int WIN_IDX_W  = $clog2(WINDOW_LEN + 1);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [SAMPLE_W-1:0]  sample_t;
    typedef logic [WIN_IDX_W-1:0] win_idx_t;
    typedef logic [WIN_IDX_W-1:0] fill_cnt_t;  // 0 .. WINDOW_LEN

endpackage
